// ==== bench/axil_apb_tb.sv ====
// Testbench for the AXI4-Lite to APB subsystem with table-driven transfers and back-pressure
`default_nettype none

module axil_apb_tb
  import apb_bridge_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGS    = 16;
  localparam int WAIT_STATES = 1;
  localparam int CLK_PERIOD  = 40;
  localparam int N_TESTS     = 16;
  // Forty cycles for each table entry and each reset read
  localparam int WATCHDOG_NS = (N_TESTS + NUM_REGS) * 40 * CLK_PERIOD;

  // Entry kinds
  localparam logic [1:0] K_WR   = 2'd0;
  localparam logic [1:0] K_RD   = 2'd1;
  localparam logic [1:0] K_BOTH = 2'd2;

  typedef struct packed {
    logic [1:0]        kind;
    logic              w_late;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] raddr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] exp_data;
    axi_resp_e         exp_resp;
  } test_vec_t;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  integer    seed;
  int        n_loaded;
  test_vec_t tests [N_TESTS];
  string     names [N_TESTS];

  axil_apb_subsystem #(
    .NUM_REGS    (NUM_REGS),
    .WAIT_STATES (WAIT_STATES)
  ) uut (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal;
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    fail_run($sformatf("ERROR %s: %s expected %h actual %h", name, field, exp, act));
  endtask

  task automatic add_test(input string name, input logic [1:0] kind, input logic w_late,
                          input logic [ADDR_W-1:0] addr, input logic [ADDR_W-1:0] raddr,
                          input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                          input logic [DATA_W-1:0] exp_data, input axi_resp_e exp_resp);
    names[n_loaded] = name;
    tests[n_loaded] = '{kind, w_late, addr, raddr, data, strb, exp_data, exp_resp};
    n_loaded++;
  endtask

  // Expected values assume every register starts at zero
  task automatic load_table();
    n_loaded = 0;
    add_test("wr_full", K_WR, 0, 16'h0004, '0, 32'hdead_beef, 4'hf, '0, RESP_OKAY);
    add_test("rd_full", K_RD, 0, '0, 16'h0004, '0, '0, 32'hdead_beef, RESP_OKAY);
    add_test("wr_w_late", K_WR, 1, 16'h0008, '0, 32'h1234_5678, 4'hf, '0, RESP_OKAY);
    add_test("rd_w_late", K_RD, 0, '0, 16'h0008, '0, '0, 32'h1234_5678, RESP_OKAY);
    add_test("wr_part_lo", K_WR, 0, 16'h0004, '0, 32'h1122_3344, 4'h5, '0, RESP_OKAY);
    add_test("rd_part_lo", K_RD, 0, '0, 16'h0004, '0, '0, 32'hde22_be44, RESP_OKAY);
    add_test("wr_part_hi", K_WR, 1, 16'h0008, '0, 32'ha500_0000, 4'h8, '0, RESP_OKAY);
    add_test("rd_part_hi", K_RD, 0, '0, 16'h0008, '0, '0, 32'ha534_5678, RESP_OKAY);
    add_test("wr_reg0", K_WR, 0, 16'h0000, '0, 32'hcafe_f00d, 4'hf, '0, RESP_OKAY);
    add_test("wr_range", K_WR, 0, 16'h0040, '0, 32'hffff_ffff, 4'hf, '0, RESP_SLVERR);
    add_test("rd_range", K_RD, 0, '0, 16'h0040, '0, '0, 32'h0, RESP_SLVERR);
    add_test("wr_misalign", K_WR, 1, 16'h0002, '0, 32'h5555_5555, 4'hf, '0, RESP_SLVERR);
    add_test("rd_misalign", K_RD, 0, '0, 16'h0006, '0, '0, 32'h0, RESP_SLVERR);
    add_test("rd_reg0_kept", K_RD, 0, '0, 16'h0000, '0, '0, 32'hcafe_f00d, RESP_OKAY);
    add_test("wr_rd_same", K_BOTH, 0, 16'h000c, 16'h0004, 32'h0bad_c0de, 4'hf,
             32'hde22_be44, RESP_OKAY);
    add_test("rd_after_same", K_RD, 0, '0, 16'h000c, '0, '0, 32'h0bad_c0de, RESP_OKAY);
  endtask

  // Raise AW, W and AR as asked and drop each one after its beat
  task automatic drive_requests(input logic do_wr, input logic do_rd, input logic w_late,
                                input test_vec_t t);
    logic aw_done;
    logic w_done;
    logic ar_done;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    aw_done = !do_wr;
    w_done  = !do_wr;
    ar_done = !do_rd;
    if (do_wr) begin
      awaddr  = t.addr;
      awvalid = 1'b1;
      wdata   = t.wdata;
      wstrb   = t.strb;
      wvalid  = !w_late;
    end
    if (do_rd) begin
      araddr  = t.raddr;
      arvalid = 1'b1;
    end
    while (!aw_done || !w_done || !ar_done) begin
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      ar_fire = arvalid && arready;
      @(posedge clk);
      #2;
      if (aw_fire) begin
        awvalid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_fire) begin
        wvalid = 1'b0;
        w_done = 1'b1;
      end
      if (ar_fire) begin
        arvalid = 1'b0;
        ar_done = 1'b1;
      end
      // Late W beat starts one cycle after AW
      if (!w_done && !wvalid) wvalid = 1'b1;
    end
  endtask

  // Wait for B and R with random stalls on the ready lines
  task automatic collect_responses(input string name, input logic want_b, input logic want_r,
                                   input test_vec_t t);
    logic b_done;
    logic r_done;
    logic b_seen;
    logic r_seen;
    logic b_fire;
    logic r_fire;
    int   b_stall;
    int   r_stall;
    b_done  = !want_b;
    r_done  = !want_r;
    b_seen  = 1'b0;
    r_seen  = 1'b0;
    b_stall = $random(seed) & 3;
    r_stall = $random(seed) & 3;
    while (!b_done || !r_done) begin
      if (b_seen && !b_done) assert (bvalid) else fail_run({name, ": bvalid fell early"});
      if (r_seen && !r_done) assert (rvalid) else fail_run({name, ": rvalid fell early"});
      if (bvalid) begin
        assert (!b_done) else fail_run({name, ": write response that was not expected"});
        b_seen = 1'b1;
        assert (bresp == t.exp_resp)
        else report_mismatch(name, "bresp", 32'(t.exp_resp), 32'(bresp));
        if (b_stall == 0) bready = 1'b1;
        else b_stall--;
      end
      if (rvalid) begin
        assert (!r_done) else fail_run({name, ": read response that was not expected"});
        r_seen = 1'b1;
        assert (rresp == t.exp_resp)
        else report_mismatch(name, "rresp", 32'(t.exp_resp), 32'(rresp));
        assert (rdata == t.exp_data) else report_mismatch(name, "rdata", t.exp_data, rdata);
        if (r_stall == 0) rready = 1'b1;
        else r_stall--;
      end
      b_fire = bvalid && bready;
      r_fire = rvalid && rready;
      @(posedge clk);
      #2;
      if (b_fire) begin
        bready = 1'b0;
        b_done = 1'b1;
        assert (!bvalid) else fail_run({name, ": write response repeated after handshake"});
      end
      if (r_fire) begin
        rready = 1'b0;
        r_done = 1'b1;
        assert (!rvalid) else fail_run({name, ": read response repeated after handshake"});
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run("timeout: the transfers did not finish in the allowed time");
  end

  initial begin : main_seq
    test_vec_t t;
    logic      is_wr;
    logic      is_rd;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    seed    = 32'h9e5c_4d52;
    load_table();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    assert (!bvalid && !rvalid) else fail_run("bvalid or rvalid high right after reset");

    // Every register reads zero after reset
    for (int i = 0; i < NUM_REGS; i++) begin
      t = '{K_RD, 1'b0, '0, ADDR_W'(4 * i), '0, '0, '0, RESP_OKAY};
      drive_requests(1'b0, 1'b1, 1'b0, t);
      collect_responses($sformatf("reset_rd_%0d", i), 1'b0, 1'b1, t);
    end

    for (int k = 0; k < N_TESTS; k++) begin
      t = tests[k];
      is_wr = (t.kind == K_WR) || (t.kind == K_BOTH);
      is_rd = (t.kind == K_RD) || (t.kind == K_BOTH);
      assert (!bvalid && !rvalid) else fail_run({names[k], ": response left over before start"});
      drive_requests(is_wr, is_rd, t.w_late, t);
      collect_responses(names[k], is_wr, is_rd, t);
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/apb_bridge_pkg.sv
source/axil_request_decode.sv
source/apb_transfer_execute.sv
source/axil_response_result.sv
source/apb_register_bank.sv
source/axil_apb_subsystem.sv
bench/axil_apb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI4-Lite to APB subsystem simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module axil_apb_tb \
  -f build.f \
  -o axil_apb_sim

./obj_dir/axil_apb_sim

// ==== source/apb_bridge_pkg.sv ====
// Bridge package with bus widths, transfer structs and the enums shared by all stages
`default_nettype none

package apb_bridge_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // APB requester phases
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SETUP  = 2'd1,
    ST_ACCESS = 2'd2,
    ST_DONE   = 2'd3
  } xfer_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // 53-bit request from decode to execute
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } apb_req_t;

  // 35-bit response from execute to result
  typedef struct packed {
    op_e               op;
    logic [DATA_W-1:0] rdata;
    axi_resp_e         resp;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== source/apb_register_bank.sv ====
// APB completer register file with byte strobes, wait states and bad address error
`default_nettype none

module apb_register_bank
  import apb_bridge_pkg::*;
#(
  parameter int NUM_REGS    = 16,
  parameter int WAIT_STATES = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic [STRB_W-1:0] pstrb,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic [CNT_W-1:0]  wait_cnt;
  logic [ADDR_W-3:0] word_idx;
  logic [IDX_W-1:0]  idx;
  logic              access;
  logic              bad;

  assign access   = psel && penable;
  assign word_idx = paddr[ADDR_W-1:2];
  assign idx      = word_idx[IDX_W-1:0];
  // Misaligned or past the last register
  assign bad      = (paddr[1:0] != 2'b00) || (32'(word_idx) >= NUM_REGS);

  assign pready  = access && (wait_cnt == CNT_W'(WAIT_STATES));
  assign pslverr = pready && bad;
  assign prdata  = bad ? '0 : regs[idx];

  // Wait state count restarts after every transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (access && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (pready && pwrite && !bad) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (pstrb[b]) regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/apb_transfer_execute.sv ====
// APB requester FSM running one setup and one access phase per request
`default_nettype none

module apb_transfer_execute
  import apb_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              xfer_req,
  input  apb_req_t          xfer,
  output logic              xfer_ack,
  output logic              rsp_req,
  output apb_rsp_t          rsp,
  input  logic              rsp_ack,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output logic [ADDR_W-1:0] paddr,
  output logic [DATA_W-1:0] pwdata,
  output logic [STRB_W-1:0] pstrb,
  input  logic [DATA_W-1:0] prdata,
  input  logic              pready,
  input  logic              pslverr
);

  xfer_state_e state;

  assign psel    = (state == ST_SETUP) || (state == ST_ACCESS);
  assign penable = (state == ST_ACCESS);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      xfer_ack <= 1'b0;
      rsp_req  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (xfer_req && !xfer_ack) state <= ST_SETUP;
        ST_SETUP: state <= ST_ACCESS;
        ST_ACCESS: begin
          if (pready) begin
            rsp_req <= 1'b1;
            state   <= ST_DONE;
          end
        end
        ST_DONE: begin
          // Release decode once result holds the response
          if (rsp_req && rsp_ack) begin
            rsp_req  <= 1'b0;
            xfer_ack <= 1'b1;
          end else if (xfer_ack && !xfer_req && !rsp_ack) begin
            xfer_ack <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Bus payload and captured response
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && xfer_req && !xfer_ack) begin
      pwrite <= (xfer.op == OP_WRITE);
      paddr  <= xfer.addr;
      pwdata <= xfer.wdata;
      pstrb  <= (xfer.op == OP_WRITE) ? xfer.wstrb : '0;
    end
    if (state == ST_ACCESS && pready) begin
      rsp.op    <= pwrite ? OP_WRITE : OP_READ;
      rsp.rdata <= prdata;
      rsp.resp  <= pslverr ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assert property (@(posedge clk) disable iff (rst) penable |-> psel);

  // Address and direction hold from setup through the last access cycle
  assert property (@(posedge clk) disable iff (rst)
    psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite));

endmodule

`default_nettype wire

// ==== source/axil_apb_subsystem.sv ====
// AXI4-Lite to APB bridge stages joined to one APB register bank
`default_nettype none

module axil_apb_subsystem
  import apb_bridge_pkg::*;
#(
  parameter int NUM_REGS    = 16,
  parameter int WAIT_STATES = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  logic              xfer_req;
  logic              xfer_ack;
  apb_req_t          xfer;
  logic              rsp_req;
  logic              rsp_ack;
  apb_rsp_t          rsp;

  // Internal APB bus
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [STRB_W-1:0] pstrb;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  axil_request_decode u_decode (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .araddr, .arvalid, .arready, .xfer_req, .xfer, .xfer_ack
  );

  apb_transfer_execute u_execute (
    .clk, .rst, .xfer_req, .xfer, .xfer_ack, .rsp_req, .rsp, .rsp_ack,
    .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready, .pslverr
  );

  axil_response_result u_result (
    .clk, .rst, .rsp_req, .rsp, .rsp_ack, .bresp, .bvalid, .bready,
    .rdata, .rresp, .rvalid, .rready
  );

  apb_register_bank #(
    .NUM_REGS    (NUM_REGS),
    .WAIT_STATES (WAIT_STATES)
  ) u_bank (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
    .prdata, .pready, .pslverr
  );

endmodule

`default_nettype wire

// ==== source/axil_request_decode.sv ====
// AXI4-Lite request capture with round-robin choice of the next APB transfer
`default_nettype none

module axil_request_decode
  import apb_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic              xfer_req,
  output apb_req_t          xfer,
  input  logic              xfer_ack
);

  logic              active;
  logic              aw_full;
  logic              w_full;
  logic              ar_full;
  logic [ADDR_W-1:0] aw_addr;
  logic [ADDR_W-1:0] ar_addr;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              last_wr;
  logic              wr_ok;
  logic              rd_ok;
  logic              pick_wr;
  logic              rd_pending;
  logic              issue;

  // Ready stays low until the first cycle out of reset
  assign awready    = active && !aw_full;
  assign wready     = active && !w_full;
  assign rd_pending = xfer_req && (xfer.op == OP_READ);
  assign arready    = active && !ar_full && !rd_pending;

  assign wr_ok   = aw_full && w_full;
  assign rd_ok   = ar_full;
  // Write wins unless a read is waiting and the last one served was a write
  assign pick_wr = wr_ok && (!rd_ok || !last_wr);
  assign issue   = !xfer_req && !xfer_ack && (wr_ok || rd_ok);

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      aw_full  <= 1'b0;
      w_full   <= 1'b0;
      ar_full  <= 1'b0;
      last_wr  <= 1'b0;
      xfer_req <= 1'b0;
    end else begin
      active <= 1'b1;
      if (awvalid && awready) aw_full <= 1'b1;
      if (wvalid && wready) w_full <= 1'b1;
      if (arvalid && arready) ar_full <= 1'b1;
      if (xfer_req && xfer_ack) begin
        xfer_req <= 1'b0;
        // Free the holding registers of the transfer just finished
        if (xfer.op == OP_WRITE) begin
          aw_full <= 1'b0;
          w_full  <= 1'b0;
        end else begin
          ar_full <= 1'b0;
        end
      end else if (issue) begin
        xfer_req <= 1'b1;
        last_wr  <= pick_wr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) aw_addr <= awaddr;
    if (wvalid && wready) begin
      w_data <= wdata;
      w_strb <= wstrb;
    end
    if (arvalid && arready) ar_addr <= araddr;
    if (issue) begin
      if (pick_wr) begin
        xfer <= '{op: OP_WRITE, addr: aw_addr, wdata: w_data, wstrb: w_strb};
      end else begin
        xfer <= '{op: OP_READ, addr: ar_addr, wdata: '0, wstrb: '0};
      end
    end
  end

  // Request payload is held for the whole handshake
  assert property (@(posedge clk) disable iff (rst)
    xfer_req |=> !xfer_req || $stable(xfer));

endmodule

`default_nettype wire

// ==== source/axil_response_result.sv ====
// Response slots for the AXI4-Lite B and R channels
`default_nettype none

module axil_response_result
  import apb_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rsp_req,
  input  apb_rsp_t          rsp,
  output logic              rsp_ack,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  axi_resp_e b_resp;
  axi_resp_e r_resp;
  logic      take;

  // Accept only with both slots empty
  assign take  = rsp_req && !rsp_ack && !bvalid && !rvalid;
  assign bresp = b_resp;
  assign rresp = r_resp;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rsp_ack <= 1'b0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (rvalid && rready) rvalid <= 1'b0;
      if (take) begin
        rsp_ack <= 1'b1;
        if (rsp.op == OP_WRITE) bvalid <= 1'b1;
        else rvalid <= 1'b1;
      end else if (!rsp_req && rsp_ack) begin
        rsp_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (rsp.op == OP_WRITE) begin
        b_resp <= rsp.resp;
      end else begin
        rdata  <= rsp.rdata;
        r_resp <= rsp.resp;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);
  assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire
